/* hdl/resample_cfg_pkg.sv */
package resample_cfg_pkg;

    // datapath widths
    localparam int SAMPLE_W = 24;
    localparam int COEFF_W = 16;

    // filter shape
    localparam int FIR_DEPTH = 32;
    localparam int FIR_DEPTH_LOG2 = 5;
    localparam int NUM_PHASES = 2;
    localparam int NUM_PHASES_LOG2 = 1;
    localparam int DECIM = 1;

    // load, load data, multiply, accumulate
    localparam int MULT_LATENCY = 4;
    localparam int PIPE_DEPTH = 2 + MULT_LATENCY + 1;

    localparam int BANK_ADDR_W = NUM_PHASES_LOG2 + FIR_DEPTH_LOG2;
    localparam int RB_LEN_LOG2 = 6;
    localparam int NUM_CH = 2;

    // coefficients are Q15
    localparam int Q_SHIFT = 15;

    // stand-in filter taps, easy to predict
    function automatic logic signed [COEFF_W-1:0] coeff_at(input int phase, input int tap);
        return COEFF_W'(256 * (1 + phase * FIR_DEPTH + tap));
    endfunction

endpackage

/* hdl/resample_types_pkg.sv */
package resample_types_pkg;

    import resample_cfg_pkg::*;

    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [COEFF_W-1:0] coeff_t;

    // full multiplier product before the Q15 shift
    typedef logic signed [SAMPLE_W+COEFF_W-1:0] prod_t;

    typedef enum logic [2:0] {
        RS_IDLE,
        RS_RESULT,
        RS_CALC_PENDING,
        RS_CALC,
        RS_NEXT_PHASE
    } rs_state_e;

endpackage

/* hdl/mult_if.sv */
`timescale 1ns/1ps

interface mult_if;
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    logic req;
    logic grant;
    sample_t mpcand;
    coeff_t mplier;
    sample_t mprod;
    logic [BANK_ADDR_W-1:0] bank_addr;
    coeff_t bank_data;

    // engine side drives zeros when idle so the hub can OR
    modport engine (output req, mpcand, mplier, bank_addr,
                    input grant, mprod, bank_data);

    modport hub (input req, mpcand, mplier, bank_addr,
                 output grant, mprod, bank_data);

endinterface

/* hdl/sample_ringbuf.sv */
`timescale 1ns/1ps

module sample_ringbuf (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        we_i,
    input  resample_types_pkg::sample_t                 data_i,
    input  logic                                        pop_i,
    input  logic [resample_cfg_pkg::FIR_DEPTH_LOG2-1:0] offset_i,
    output resample_types_pkg::sample_t                 data_o
);
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    sample_t mem [2**RB_LEN_LOG2];
    logic [RB_LEN_LOG2-1:0] wr_ptr_q;
    logic [RB_LEN_LOG2-1:0] rd_ptr_q;
    logic [RB_LEN_LOG2-1:0] rd_addr;

    // tap offset relative to the oldest unconsumed sample
    assign rd_addr = rd_ptr_q + RB_LEN_LOG2'(offset_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (we_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[wr_ptr_q] <= data_i;
        end
        data_o <= mem[rd_addr];
    end

endmodule

/* hdl/coeff_bank.sv */
`timescale 1ns/1ps

module coeff_bank (
    input  logic                                     clk,
    input  logic [resample_cfg_pkg::BANK_ADDR_W-1:0] addr_i,
    output resample_types_pkg::coeff_t               data_o
);
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    coeff_t rom [2**BANK_ADDR_W];

    // upper address bit is the phase, lower bits the tap
    for (genvar i = 0; i < 2**BANK_ADDR_W; i++) begin : g_rom
        assign rom[i] = coeff_at(i / FIR_DEPTH, i % FIR_DEPTH);
    end

    // one cycle read latency, the engine pipeline counts on it
    always_ff @(posedge clk) begin
        data_o <= rom[addr_i];
    end

endmodule

/* hdl/shared_multiplier.sv */
`timescale 1ns/1ps

module shared_multiplier (
    input  logic                        clk,
    input  logic                        rst,
    input  resample_types_pkg::sample_t a_i,
    input  resample_types_pkg::coeff_t  b_i,
    output resample_types_pkg::sample_t p_o
);
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    prod_t pipe_q [MULT_LATENCY];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MULT_LATENCY; i++) begin
                pipe_q[i] <= '0;
            end
        end else begin
            pipe_q[0] <= a_i * b_i;
            // plain delay stages for retiming
            for (int i = 1; i < MULT_LATENCY; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    // drop the Q15 fraction and keep the sample width
    assign p_o = SAMPLE_W'(pipe_q[MULT_LATENCY-1] >>> Q_SHIFT);

endmodule

/* hdl/resampler_1ch.sv */
`timescale 1ns/1ps

module resampler_1ch (
    input  logic                                        clk,
    input  logic                                        rst,
    mult_if.engine                                      mp,
    output logic                                        rb_pop_o,
    output logic [resample_cfg_pkg::FIR_DEPTH_LOG2-1:0] rb_offset_o,
    input  resample_types_pkg::sample_t                 rb_data_i,
    input  logic                                        pop_i,
    output resample_types_pkg::sample_t                 data_o,
    output logic                                        ack_o
);
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    rs_state_e state_q;
    logic [NUM_PHASES_LOG2-1:0] phase_q;
    logic [NUM_PHASES_LOG2-1:0] pop_cnt_q;
    // one bit wider, runs on while the pipeline drains
    logic [FIR_DEPTH_LOG2:0] tap_q;
    sample_t acc_q;
    sample_t sample_q;
    coeff_t coeff_q;
    logic active;
    logic wrap_pop;

    // req stays up through calc so the hub can hold the grant
    assign mp.req = (state_q == RS_RESULT) || (state_q == RS_CALC_PENDING)
                    || (state_q == RS_CALC);
    assign active = mp.req && mp.grant;

    // stage 0, tap address to ring buffer and bank
    assign rb_offset_o = tap_q[FIR_DEPTH_LOG2-1:0];
    assign mp.bank_addr = active ? {phase_q, tap_q[FIR_DEPTH_LOG2-1:0]} : '0;

    assign mp.mpcand = sample_q;
    assign mp.mplier = coeff_q;

    assign wrap_pop = pop_cnt_q >= NUM_PHASES - DECIM;
    assign rb_pop_o = (state_q == RS_NEXT_PHASE) && wrap_pop;

    assign ack_o = (state_q == RS_RESULT);
    assign data_o = ack_o ? acc_q : '0;

    // stage 1, operand registers, zero outside calc
    always_ff @(posedge clk) begin
        if (state_q == RS_CALC) begin
            sample_q <= rb_data_i;
            coeff_q <= mp.bank_data;
        end else begin
            sample_q <= '0;
            coeff_q <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= RS_IDLE;
            phase_q <= '0;
            pop_cnt_q <= '0;
            tap_q <= '0;
            acc_q <= '0;
        end else begin
            tap_q <= '0;
            case (state_q)
                RS_IDLE: begin
                    if (pop_i) begin
                        state_q <= RS_RESULT;
                    end
                end
                RS_RESULT: begin
                    // previous result is on data_o this cycle
                    acc_q <= '0;
                    if (mp.grant) begin
                        tap_q <= 1'b1;
                        state_q <= RS_CALC;
                    end else begin
                        state_q <= RS_CALC_PENDING;
                    end
                end
                RS_CALC_PENDING: begin
                    if (mp.grant) begin
                        tap_q <= 1'b1;
                        state_q <= RS_CALC;
                    end
                end
                RS_CALC: begin
                    // products of taps 0 to FIR_DEPTH-1 come out here
                    if (tap_q >= PIPE_DEPTH - 1 && tap_q < FIR_DEPTH + PIPE_DEPTH - 1) begin
                        acc_q <= acc_q + mp.mprod;
                    end
                    if (tap_q == FIR_DEPTH + PIPE_DEPTH - 1) begin
                        state_q <= RS_NEXT_PHASE;
                    end else begin
                        tap_q <= tap_q + 1'b1;
                    end
                end
                RS_NEXT_PHASE: begin
                    phase_q <= (phase_q == NUM_PHASES - 1) ? '0 : phase_q + 1'b1;
                    if (wrap_pop) begin
                        pop_cnt_q <= NUM_PHASES_LOG2'(pop_cnt_q + DECIM - NUM_PHASES);
                    end else begin
                        pop_cnt_q <= NUM_PHASES_LOG2'(pop_cnt_q + DECIM);
                    end
                    state_q <= RS_IDLE;
                end
                default: begin
                    state_q <= RS_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/upsample2x.sv */
`timescale 1ns/1ps

module upsample2x (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [resample_cfg_pkg::NUM_CH-1:0] in_we_i,
    input  resample_types_pkg::sample_t         data_in_i,
    output logic [resample_cfg_pkg::NUM_CH-1:0] in_pop_o,
    input  logic [resample_cfg_pkg::NUM_CH-1:0] out_pop_i,
    output resample_types_pkg::sample_t         data_out_o,
    output logic [resample_cfg_pkg::NUM_CH-1:0] out_ack_o
);
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    mult_if mp [NUM_CH] ();

    logic [NUM_CH-1:0] req;
    logic [NUM_CH-1:0] grant;
    logic [NUM_CH-1:0] grant_q;

    logic [NUM_CH-1:0] rb_pop;
    logic [FIR_DEPTH_LOG2-1:0] rb_offset [NUM_CH];
    sample_t rb_data [NUM_CH];
    sample_t eng_data [NUM_CH];

    logic [BANK_ADDR_W-1:0] bank_addr;
    coeff_t bank_data;
    sample_t mpcand;
    coeff_t mplier;
    sample_t prod;

    assign req = {mp[1].req, mp[0].req};

    // owner keeps the grant while it still requests
    // otherwise channel 0 wins a tie
    always_comb begin
        if ((grant_q & req) != '0) begin
            grant = grant_q;
        end else if (req[0]) begin
            grant = 2'b01;
        end else if (req[1]) begin
            grant = 2'b10;
        end else begin
            grant = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_q <= '0;
        end else begin
            grant_q <= grant;
        end
    end

    // idle engines drive zeros
    assign bank_addr = mp[0].bank_addr | mp[1].bank_addr;
    assign mpcand = mp[0].mpcand | mp[1].mpcand;
    assign mplier = mp[0].mplier | mp[1].mplier;
    assign data_out_o = eng_data[0] | eng_data[1];

    assign in_pop_o = rb_pop;

    coeff_bank i_coeff_bank (
        .clk    (clk),
        .addr_i (bank_addr),
        .data_o (bank_data)
    );

    shared_multiplier i_shared_multiplier (
        .clk (clk),
        .rst (rst),
        .a_i (mpcand),
        .b_i (mplier),
        .p_o (prod)
    );

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        assign mp[ch].grant = grant[ch];
        assign mp[ch].mprod = prod;
        assign mp[ch].bank_data = bank_data;

        sample_ringbuf i_ringbuf (
            .clk      (clk),
            .rst      (rst),
            .we_i     (in_we_i[ch]),
            .data_i   (data_in_i),
            .pop_i    (rb_pop[ch]),
            .offset_i (rb_offset[ch]),
            .data_o   (rb_data[ch])
        );

        resampler_1ch i_engine (
            .clk         (clk),
            .rst         (rst),
            .mp          (mp[ch]),
            .rb_pop_o    (rb_pop[ch]),
            .rb_offset_o (rb_offset[ch]),
            .rb_data_i   (rb_data[ch]),
            .pop_i       (out_pop_i[ch]),
            .data_o      (eng_data[ch]),
            .ack_o       (out_ack_o[ch])
        );
    end

endmodule

/* dv/upsample2x_tb.sv */
`timescale 1ns/1ps

module upsample2x_tb;
    import resample_cfg_pkg::*;
    import resample_types_pkg::*;

    localparam int CLK_HALF = 4;
    localparam int IDLE_GAP = 45;
    localparam int CALC_CYCLES = FIR_DEPTH + PIPE_DEPTH;
    localparam int HIST_LEN = 256;
    localparam int NUM_TESTS = 5;
    localparam int OUTPUTS_PER_TEST = 16;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * OUTPUTS_PER_TEST * 100;
    localparam sample_t DC_LEVEL = 24'h001000;

    logic clk;
    logic rst;
    logic [NUM_CH-1:0] in_we_i;
    sample_t data_in_i;
    logic [NUM_CH-1:0] in_pop_o;
    logic [NUM_CH-1:0] out_pop_i;
    sample_t data_out_o;
    logic [NUM_CH-1:0] out_ack_o;

    // reference model state, one set per channel
    sample_t hist [NUM_CH][HIST_LEN];
    int wr_cnt [NUM_CH];
    int rd_ptr_m [NUM_CH];
    int phase_m [NUM_CH];
    sample_t last_result [NUM_CH];
    logic [NUM_CH-1:0] fill_dc;
    logic [31:0] rng_state;

    upsample2x i_upsample2x (
        .clk        (clk),
        .rst        (rst),
        .in_we_i    (in_we_i),
        .data_in_i  (data_in_i),
        .in_pop_o   (in_pop_o),
        .out_pop_i  (out_pop_i),
        .data_out_o (data_out_o),
        .out_ack_o  (out_ack_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // tap value rule, 256 * (1 + phase * 32 + tap)
    function automatic longint coeff_ref(input int phase, input int tap);
        return 256 * (1 + phase * FIR_DEPTH + tap);
    endfunction

    // Q15 product, truncated to the sample width, summed modulo 2^24
    function automatic sample_t expected_sum(input int ch);
        sample_t acc;
        longint prod;
        acc = '0;
        for (int t = 0; t < FIR_DEPTH; t++) begin
            prod = longint'(hist[ch][rd_ptr_m[ch] + t]) * coeff_ref(phase_m[ch], t);
            acc = acc + sample_t'(prod >>> Q_SHIFT);
        end
        return acc;
    endfunction

    // every product is exact at this level so the taps sum in closed form
    function automatic sample_t dc_sum(input int phase);
        longint tap_sum;
        tap_sum = FIR_DEPTH * (1 + phase * FIR_DEPTH) + FIR_DEPTH * (FIR_DEPTH - 1) / 2;
        return sample_t'((longint'(DC_LEVEL) * 256 * tap_sum) >>> Q_SHIFT);
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_sample(input int ch, input sample_t value);
        in_we_i = '0;
        in_we_i[ch] = 1'b1;
        data_in_i = value;
        hist[ch][wr_cnt[ch]] = value;
        wr_cnt[ch]++;
        next_cycle();
        in_we_i = '0;
        data_in_i = '0;
    endtask

    // keep a full window of 32 samples ahead of the read pointer
    task automatic top_up(input int ch);
        sample_t value;
        while (wr_cnt[ch] < rd_ptr_m[ch] + FIR_DEPTH) begin
            if (fill_dc[ch]) begin
                value = DC_LEVEL;
            end else begin
                value = sample_t'(next_random());
            end
            write_sample(ch, value);
        end
    endtask

    // result of the calculation that this pop starts
    task automatic advance_model(input int ch);
        last_result[ch] = expected_sum(ch);
        if (phase_m[ch] == NUM_PHASES - 1) begin
            rd_ptr_m[ch]++;
        end
        phase_m[ch] = (phase_m[ch] + DECIM) % NUM_PHASES;
    endtask

    task automatic request_output(input int ch, output sample_t acked, output int pops);
        sample_t exp_ack;
        int exp_pops;
        logic [NUM_CH-1:0] mask;
        top_up(ch);
        exp_ack = last_result[ch];
        exp_pops = (phase_m[ch] == NUM_PHASES - 1) ? 1 : 0;
        advance_model(ch);
        mask = '0;
        mask[ch] = 1'b1;
        out_pop_i = mask;
        next_cycle();
        out_pop_i = '0;
        check_value("out_ack_o", out_ack_o, mask);
        check_value("data_out_o", data_out_o, exp_ack);
        acked = data_out_o;
        pops = 0;
        repeat (IDLE_GAP) begin
            next_cycle();
            check_value("out_ack_o idle", out_ack_o, '0);
            check_value("data_out_o idle", data_out_o, '0);
            check_value("in_pop_o other channel", in_pop_o & ~mask, '0);
            if (in_pop_o[ch]) begin
                pops++;
            end
        end
        check_value("in_pop_o pulses", pops, exp_pops);
    endtask

    task automatic reset_state_test();
        sample_t acked;
        int pops;
        check_value("data_out_o after reset", data_out_o, '0);
        check_value("out_ack_o after reset", out_ack_o, '0);
        check_value("in_pop_o after reset", in_pop_o, '0);
        fill_dc = 2'b01;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            request_output(ch, acked, pops);
            check_value("first ack value", acked, '0);
        end
    endtask

    task automatic dc_response_test();
        sample_t acked;
        int pops;
        int prev_phase;
        for (int i = 0; i < 6; i++) begin
            // phase of the calculation whose result this ack carries
            prev_phase = (phase_m[0] + NUM_PHASES - DECIM) % NUM_PHASES;
            request_output(0, acked, pops);
            check_value("dc phase sum", acked, dc_sum(prev_phase));
        end
    endtask

    task automatic input_pop_test();
        sample_t acked;
        int pops;
        int total;
        fill_dc = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            total = 0;
            for (int i = 0; i < 4; i++) begin
                request_output(ch, acked, pops);
                total += pops;
            end
            check_value("in_pop_o per two outputs", total, 2);
        end
    endtask

    task automatic random_stereo_test();
        sample_t acked;
        int pops;
        for (int i = 0; i < 8; i++) begin
            request_output(0, acked, pops);
            request_output(1, acked, pops);
        end
    endtask

    task automatic arbitration_test();
        sample_t acked;
        sample_t exp0;
        sample_t exp1;
        int pops;
        int pop_cnt [NUM_CH];
        int pop_cycle [NUM_CH];
        // both channels on phase 1 so both pulse in_pop_o when done
        for (int ch = 0; ch < NUM_CH; ch++) begin
            if (phase_m[ch] != NUM_PHASES - 1) begin
                request_output(ch, acked, pops);
            end
            pop_cnt[ch] = 0;
            pop_cycle[ch] = 0;
        end
        top_up(0);
        top_up(1);
        exp0 = last_result[0];
        exp1 = last_result[1];
        advance_model(0);
        advance_model(1);
        out_pop_i = '1;
        next_cycle();
        out_pop_i = '0;
        check_value("out_ack_o both", out_ack_o, 2'b11);
        check_value("data_out_o both", data_out_o, exp0 | exp1);
        for (int i = 1; i <= 2 * IDLE_GAP; i++) begin
            next_cycle();
            check_value("out_ack_o busy", out_ack_o, '0);
            check_value("data_out_o busy", data_out_o, '0);
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (in_pop_o[ch]) begin
                    pop_cnt[ch]++;
                    pop_cycle[ch] = i;
                end
            end
        end
        check_value("in_pop_o[0] pulses", pop_cnt[0], 1);
        check_value("in_pop_o[1] pulses", pop_cnt[1], 1);
        check_value("channel 0 done first", pop_cycle[0] < pop_cycle[1], 1);
        check_value("exclusive multiplier", pop_cycle[1] - pop_cycle[0] >= CALC_CYCLES, 1);
        // results of the shared round come back on the next acks
        request_output(0, acked, pops);
        request_output(1, acked, pops);
    endtask

    initial begin
        rst = 1'b1;
        in_we_i = '0;
        data_in_i = '0;
        out_pop_i = '0;
        rng_state = 32'd20010;
        fill_dc = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            wr_cnt[ch] = 0;
            rd_ptr_m[ch] = 0;
            phase_m[ch] = 0;
            last_result[ch] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        next_cycle();
        reset_state_test();
        dc_response_test();
        input_pop_test();
        random_stereo_test();
        arbitration_test();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* files.f */
hdl/resample_cfg_pkg.sv
hdl/resample_types_pkg.sv
hdl/mult_if.sv
hdl/sample_ringbuf.sv
hdl/coeff_bank.sv
hdl/shared_multiplier.sv
hdl/resampler_1ch.sv
hdl/upsample2x.sv
dv/upsample2x_tb.sv

/* Bender.yml */
package:
  name: upsample2x

sources:
  - hdl/resample_cfg_pkg.sv
  - hdl/resample_types_pkg.sv
  - hdl/mult_if.sv
  - hdl/sample_ringbuf.sv
  - hdl/coeff_bank.sv
  - hdl/shared_multiplier.sv
  - hdl/resampler_1ch.sv
  - hdl/upsample2x.sv
  - target: test
    files:
      - dv/upsample2x_tb.sv
